// ==== mips_core.f ====
mips_isa_pkg.sv
mips_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_stage.sv
mips_core.sv
tb_mips_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_mips_core.sv ====
// Directed testbench for the five-stage core. Programs sit in a 256-word
// instruction memory and data in a 256-word data memory, both read combinationally.
// Expected writebacks are built per test from the instruction semantics.
// Writes to register zero are not collected.
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
    import mips_isa_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int N_TESTS         = 5;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int DRAIN_CYCLES    = 8; // longer than the pipeline

    typedef struct packed {
        word_t     pc;
        reg_addr_t addr;
        word_t     data;
    } wb_rec_t;

    logic      clk;
    logic      rst_n_i;
    word_t     imem_addr;
    word_t     imem_data;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    logic      dmem_we;
    word_t     debug_wb_pc;
    logic      debug_wb_we;
    reg_addr_t debug_wb_wraddr;
    word_t     debug_wb_wrdata;

    word_t     imem [256];
    word_t     dmem [256];
    word_t     rf_model [32];
    wb_rec_t   exp_q [$];
    wb_rec_t   got_q [$];
    int        prog_len;

    mips_core u_mips_core (
        .clk               (clk            ),
        .rst_n_i           (rst_n_i        ),
        .imem_addr_o       (imem_addr      ),
        .imem_data_i       (imem_data      ),
        .dmem_addr_o       (dmem_addr      ),
        .dmem_we_o         (dmem_we        ),
        .dmem_wdata_o      (dmem_wdata     ),
        .dmem_rdata_i      (dmem_rdata     ),
        .debug_wb_pc_o     (debug_wb_pc    ),
        .debug_wb_we_o     (debug_wb_we    ),
        .debug_wb_wraddr_o (debug_wb_wraddr),
        .debug_wb_wrdata_o (debug_wb_wrdata)
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (rst_n_i && dmem_we)
            dmem[dmem_addr[9:2]] <= dmem_wdata;
    end

    always @(posedge clk) begin
        if (rst_n_i && debug_wb_we && debug_wb_wraddr != '0)
            got_q.push_back({debug_wb_pc, debug_wb_wraddr, debug_wb_wrdata});
    end

    function automatic word_t fill_word(input int idx);
        return 32'hda7a_0000 | 32'(idx);
    endfunction

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t signed_less(input word_t a, input word_t b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    function automatic word_t r_type(input logic [5:0] funct, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s = %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic emit(input word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    // the write belongs to the instruction emitted last
    task automatic expect_wr(input reg_addr_t rd, input word_t value);
        if (rd != '0) begin
            exp_q.push_back({RESET_PC + 32'(4 * (prog_len - 1)), rd, value});
            rf_model[rd] = value;
        end
    endtask

    task automatic begin_test(input string name);
        @(posedge clk);
        rst_n_i <= 1'b0;
        $display("running %s", name);
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0000; // nop
            dmem[i] <= fill_word(i);
        end
        for (int r = 0; r < 32; r++)
            rf_model[r] = '0;
        exp_q.delete();
        prog_len = 0;
    endtask

    task automatic run_program;
        repeat (2) @(posedge clk);
        got_q.delete();
        rst_n_i <= 1'b1;
        while (got_q.size() < exp_q.size())
            @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk); // catch any extra writes
        check_word("number of writes", 32'(got_q.size()), 32'(exp_q.size()));
        for (int k = 0; k < exp_q.size(); k++) begin
            check_word($sformatf("debug_wb_pc_o (write %0d)", k),
                       got_q[k].pc, exp_q[k].pc);
            check_word($sformatf("debug_wb_wraddr_o (write %0d)", k),
                       32'(got_q[k].addr), 32'(exp_q[k].addr));
            check_word($sformatf("debug_wb_wrdata_o (write %0d)", k),
                       got_q[k].data, exp_q[k].data);
        end
    endtask

    task automatic test_alu;
        begin_test("alu operations");
        emit(i_type(6'h09, 0, 1, 16'd5));      // addiu $1,$0,5
        expect_wr(1, sext16(16'd5));
        emit(i_type(6'h0d, 0, 2, 16'h00f0));   // ori $2,$0,0xf0
        expect_wr(2, {16'h0000, 16'h00f0});
        emit(i_type(6'h0f, 0, 3, 16'h8000));   // lui $3,0x8000
        expect_wr(3, {16'h8000, 16'h0000});
        emit(i_type(6'h09, 0, 4, 16'hfffd));   // addiu $4,$0,-3
        expect_wr(4, sext16(16'hfffd));
        emit(r_type(6'h21, 1, 2, 5));          // addu
        expect_wr(5, rf_model[1] + rf_model[2]);
        emit(r_type(6'h23, 1, 2, 6));          // subu
        expect_wr(6, rf_model[1] - rf_model[2]);
        emit(r_type(6'h24, 2, 4, 7));          // and
        expect_wr(7, rf_model[2] & rf_model[4]);
        emit(r_type(6'h25, 1, 3, 8));          // or
        expect_wr(8, rf_model[1] | rf_model[3]);
        emit(r_type(6'h26, 2, 4, 9));          // xor
        expect_wr(9, rf_model[2] ^ rf_model[4]);
        emit(r_type(6'h2a, 4, 1, 10));         // slt of -3 and 5 gives one
        expect_wr(10, signed_less(rf_model[4], rf_model[1]));
        emit(r_type(6'h2a, 1, 4, 11));         // slt of 5 and -3 gives zero
        expect_wr(11, signed_less(rf_model[1], rf_model[4]));
        emit(r_type(6'h2a, 3, 4, 12));         // most negative word
        expect_wr(12, signed_less(rf_model[3], rf_model[4]));
        run_program();
    endtask

    task automatic test_dependencies;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        imm_a = 16'($urandom);
        imm_b = 16'($urandom);
        begin_test("back-to-back dependencies");
        emit(i_type(6'h09, 0, 1, imm_a));
        expect_wr(1, sext16(imm_a));
        emit(r_type(6'h21, 1, 1, 2));          // both operands from execute
        expect_wr(2, rf_model[1] + rf_model[1]);
        emit(r_type(6'h23, 2, 1, 3));          // execute and memory
        expect_wr(3, rf_model[2] - rf_model[1]);
        emit(r_type(6'h26, 3, 2, 4));
        expect_wr(4, rf_model[3] ^ rf_model[2]);
        emit(i_type(6'h09, 4, 5, imm_b));
        expect_wr(5, rf_model[4] + sext16(imm_b));
        emit(r_type(6'h25, 5, 3, 6));          // $3 from the register file
        expect_wr(6, rf_model[5] | rf_model[3]);
        emit(r_type(6'h2a, 6, 5, 7));
        expect_wr(7, signed_less(rf_model[6], rf_model[5]));
        run_program();
    endtask

    task automatic test_load_store;
        begin_test("load and store");
        emit(i_type(6'h09, 0, 1, 16'h0040));   // base address
        expect_wr(1, 32'h0000_0040);
        emit(i_type(6'h0f, 0, 2, 16'h1234));
        expect_wr(2, 32'h1234_0000);
        emit(i_type(6'h0d, 2, 2, 16'h5678));
        expect_wr(2, rf_model[2] | 32'h0000_5678);
        emit(i_type(6'h2b, 1, 2, 16'd8));      // sw $2,8($1)
        emit(i_type(6'h23, 1, 3, 16'd8));      // lw $3,8($1)
        expect_wr(3, rf_model[2]);
        emit(r_type(6'h21, 3, 1, 4));          // load-use
        expect_wr(4, rf_model[3] + rf_model[1]);
        emit(i_type(6'h23, 1, 5, 16'hfffc));   // lw $5,-4($1) reads word 15
        expect_wr(5, fill_word(15));
        emit(i_type(6'h2b, 1, 5, 16'd0));      // store of a loaded value
        emit(r_type(6'h23, 5, 2, 6));
        expect_wr(6, rf_model[5] - rf_model[2]);
        run_program();
        check_word("dmem[18]", dmem[18], rf_model[2]);
        check_word("dmem[16]", dmem[16], fill_word(15));
    endtask

    task automatic test_branches;
        begin_test("branches");
        emit(i_type(6'h09, 0, 1, 16'd7));
        expect_wr(1, 32'd7);
        emit(i_type(6'h09, 0, 2, 16'd7));
        expect_wr(2, 32'd7);
        emit(i_type(6'h04, 1, 2, 16'd3));      // taken beq to word 6
        emit(i_type(6'h09, 0, 3, 16'd1));      // delay slot
        expect_wr(3, 32'd1);
        emit(i_type(6'h09, 0, 4, 16'd2));      // skipped
        emit(i_type(6'h09, 0, 5, 16'd3));      // skipped
        emit(i_type(6'h05, 1, 2, 16'd4));      // bne not taken
        emit(i_type(6'h09, 0, 6, 16'd4));      // delay slot
        expect_wr(6, 32'd4);
        emit(i_type(6'h09, 6, 7, 16'd5));
        expect_wr(7, rf_model[6] + 32'd5);
        run_program();
    endtask

    task automatic test_reg_zero;
        begin_test("register zero");
        emit(i_type(6'h09, 0, 0, 16'h0055));   // addiu $0,$0,0x55
        expect_wr(0, 32'h0000_0055);
        emit(r_type(6'h21, 0, 0, 1));
        expect_wr(1, rf_model[0] + rf_model[0]);
        emit(i_type(6'h0f, 0, 0, 16'hffff));   // lui $0
        emit(r_type(6'h25, 0, 0, 2));
        expect_wr(2, rf_model[0] | rf_model[0]);
        emit(i_type(6'h23, 0, 0, 16'd4));      // lw $0,4($0)
        emit(r_type(6'h21, 0, 0, 3));
        expect_wr(3, rf_model[0] + rf_model[0]);
        emit(i_type(6'h09, 0, 4, 16'd9));
        expect_wr(4, rf_model[0] + 32'd9);
        run_program();
    endtask

    initial begin
        clk     = 1'b0;
        rst_n_i = 1'b0;
        void'($urandom(85));
        test_alu();
        test_dependencies();
        test_load_store();
        test_branches();
        test_reg_zero();
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== mips_core.sv ====
// Five-stage MIPS32 integer core, subset without CP0, TLB or HI/LO.
// Both buses are zero-wait with combinational read; there is no stall input.
// The debug port shows the MEM/WB register, one instruction per cycle.
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  wire                          clk,
    input  wire                          rst_n_i,
    output mips_isa_pkg::word_t          imem_addr_o,
    input  wire mips_isa_pkg::word_t     imem_data_i,
    output mips_isa_pkg::word_t          dmem_addr_o,
    output logic                         dmem_we_o,
    output mips_isa_pkg::word_t          dmem_wdata_o,
    input  wire mips_isa_pkg::word_t     dmem_rdata_i,
    output mips_isa_pkg::word_t          debug_wb_pc_o,
    output logic                         debug_wb_we_o,
    output mips_isa_pkg::reg_addr_t      debug_wb_wraddr_o,
    output mips_isa_pkg::word_t          debug_wb_wrdata_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    fwd_t      ex_fwd, mem_fwd;
    reg_addr_t rs_addr, rt_addr;
    word_t     rs_data, rt_data;
    word_t     branch_target;
    logic      stall, branch_taken;

    fetch_stage u_fetch (
        .clk             (clk          ),
        .rst_n_i         (rst_n_i      ),
        .stall_i         (stall        ),
        .branch_taken_i  (branch_taken ),
        .branch_target_i (branch_target),
        .imem_addr_o     (imem_addr_o  ),
        .imem_data_i     (imem_data_i  ),
        .if_id_o         (if_id        )
    );

    decode_stage u_decode (
        .clk             (clk          ),
        .rst_n_i         (rst_n_i      ),
        .if_id_i         (if_id        ),
        .ex_fwd_i        (ex_fwd       ),
        .mem_fwd_i       (mem_fwd      ),
        .rs_addr_o       (rs_addr      ),
        .rt_addr_o       (rt_addr      ),
        .rs_data_i       (rs_data      ),
        .rt_data_i       (rt_data      ),
        .stall_o         (stall        ),
        .branch_taken_o  (branch_taken ),
        .branch_target_o (branch_target),
        .id_ex_o         (id_ex        )
    );

    reg_file u_reg_file (
        .clk       (clk    ),
        .rst_n_i   (rst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wb_i      (mem_wb )
    );

    execute_stage u_execute (
        .clk      (clk    ),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex  ),
        .ex_fwd_o (ex_fwd ),
        .ex_mem_o (ex_mem )
    );

    mem_stage u_mem (
        .clk          (clk         ),
        .rst_n_i      (rst_n_i     ),
        .ex_mem_i     (ex_mem      ),
        .dmem_addr_o  (dmem_addr_o ),
        .dmem_we_o    (dmem_we_o   ),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .mem_fwd_o    (mem_fwd     ),
        .mem_wb_o     (mem_wb      )
    );

    assign debug_wb_pc_o     = mem_wb.pc;
    assign debug_wb_we_o     = mem_wb.valid && mem_wb.we;
    assign debug_wb_wraddr_o = mem_wb.waddr;
    assign debug_wb_wrdata_o = mem_wb.wdata;

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
// Data bus access and the MEM/WB register. Bus is zero-wait, word only,
// read data is expected in the same cycle as the address.
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire mips_pipe_pkg::ex_mem_t  ex_mem_i,
    output mips_isa_pkg::word_t          dmem_addr_o,
    output logic                         dmem_we_o,
    output mips_isa_pkg::word_t          dmem_wdata_o,
    input  wire mips_isa_pkg::word_t     dmem_rdata_i,
    output mips_pipe_pkg::fwd_t          mem_fwd_o,
    output mips_pipe_pkg::mem_wb_t       mem_wb_o
);
    import mips_isa_pkg::*;

    word_t wb_data;

    assign dmem_addr_o  = ex_mem_i.alu_res;
    assign dmem_we_o    = ex_mem_i.valid && ex_mem_i.store;
    assign dmem_wdata_o = ex_mem_i.st_data;

    assign wb_data = ex_mem_i.load ? dmem_rdata_i : ex_mem_i.alu_res;

    assign mem_fwd_o.we    = ex_mem_i.valid && ex_mem_i.we;
    assign mem_fwd_o.addr  = ex_mem_i.waddr;
    assign mem_fwd_o.value = wb_data; // load data is final here
    assign mem_fwd_o.load  = ex_mem_i.valid && ex_mem_i.load;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_wb_o.valid <= 1'b0;
        end else begin
            mem_wb_o.valid <= ex_mem_i.valid;
            mem_wb_o.pc    <= ex_mem_i.pc;
            mem_wb_o.we    <= ex_mem_i.we;
            mem_wb_o.waddr <= ex_mem_i.waddr;
            mem_wb_o.wdata <= wb_data;
        end
    end

    a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_we_o |-> dmem_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
// ALU and the EX/MEM register. For LW/SW the ALU sum is the byte address.
// The forward record carries the ALU result; for a load it is only the
// address, and decode stalls instead of using it.
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire mips_pipe_pkg::id_ex_t   id_ex_i,
    output mips_pipe_pkg::fwd_t          ex_fwd_o,
    output mips_pipe_pkg::ex_mem_t       ex_mem_o
);
    import mips_isa_pkg::*;

    word_t alu_res;
    logic  slt;

    assign slt = $signed(id_ex_i.opa) < $signed(id_ex_i.opb);

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: alu_res = id_ex_i.opa + id_ex_i.opb;
            ALU_SUB: alu_res = id_ex_i.opa - id_ex_i.opb;
            ALU_AND: alu_res = id_ex_i.opa & id_ex_i.opb;
            ALU_OR:  alu_res = id_ex_i.opa | id_ex_i.opb;
            ALU_XOR: alu_res = id_ex_i.opa ^ id_ex_i.opb;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, slt};
            ALU_LUI: alu_res = {id_ex_i.opb[15:0], 16'h0000};
            default: alu_res = id_ex_i.opa + id_ex_i.opb;
        endcase
    end

    assign ex_fwd_o.we    = id_ex_i.valid && id_ex_i.we;
    assign ex_fwd_o.addr  = id_ex_i.waddr;
    assign ex_fwd_o.value = alu_res;
    assign ex_fwd_o.load  = id_ex_i.valid && id_ex_i.load;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_o.valid <= 1'b0;
        end else begin
            ex_mem_o.valid   <= id_ex_i.valid;
            ex_mem_o.pc      <= id_ex_i.pc;
            ex_mem_o.alu_res <= alu_res;
            ex_mem_o.st_data <= id_ex_i.st_data;
            ex_mem_o.we      <= id_ex_i.we;
            ex_mem_o.waddr   <= id_ex_i.waddr;
            ex_mem_o.load    <= id_ex_i.load;
            ex_mem_o.store   <= id_ex_i.store;
        end
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// 32 x 32 register file, two combinational read ports, one write port.
// Register zero always reads as zero. A writeback in the same cycle is
// bypassed to the read ports.
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire mips_isa_pkg::reg_addr_t rs_addr_i,
    input  wire mips_isa_pkg::reg_addr_t rt_addr_i,
    output mips_isa_pkg::word_t          rs_data_o,
    output mips_isa_pkg::word_t          rt_data_o,
    input  wire mips_pipe_pkg::mem_wb_t  wb_i
);
    import mips_isa_pkg::*;

    word_t regs [1 << REG_AW];
    logic  wr_en;

    assign wr_en = wb_i.valid && wb_i.we && wb_i.waddr != '0;

    always_ff @(posedge clk) begin
        if (wr_en)
            regs[wb_i.waddr] <= wb_i.wdata;
    end

    assign rs_data_o = (rs_addr_i == '0) ? '0 :
                       (wr_en && wb_i.waddr == rs_addr_i) ? wb_i.wdata : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 :
                       (wr_en && wb_i.waddr == rt_addr_i) ? wb_i.wdata : regs[rt_addr_i];

    a_r0_untouched: assert property (@(posedge clk) disable iff (!rst_n_i)
        $stable(regs[0]));

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
// Decode, operand forwarding, load-use hazard and branch resolution.
// Branches resolve here on forwarded operands and always have a delay slot.
// A source produced by a load still in execute costs one bubble.
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire mips_pipe_pkg::if_id_t   if_id_i,
    input  wire mips_pipe_pkg::fwd_t     ex_fwd_i,
    input  wire mips_pipe_pkg::fwd_t     mem_fwd_i,
    output mips_isa_pkg::reg_addr_t      rs_addr_o,
    output mips_isa_pkg::reg_addr_t      rt_addr_o,
    input  wire mips_isa_pkg::word_t     rs_data_i,
    input  wire mips_isa_pkg::word_t     rt_data_i,
    output logic                         stall_o,
    output logic                         branch_taken_o,
    output mips_isa_pkg::word_t          branch_target_o,
    output mips_pipe_pkg::id_ex_t        id_ex_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs, rt, rd;
    word_t     imm_sext, imm_zext;
    word_t     rs_val, rt_val;
    alu_op_e   alu_op;
    reg_addr_t wr_addr;
    logic      use_rs, use_rt, use_imm, imm_signed;
    logic      wr_en, is_load, is_store, is_beq, is_bne;
    logic      load_hit;

    // execute has priority over memory, then the register file
    function automatic word_t fwd_pick(input reg_addr_t addr, input word_t rf_val,
                                       input fwd_t ex_f, input fwd_t mem_f);
        if (addr == '0)
            return '0;
        if (ex_f.we && ex_f.addr == addr)
            return ex_f.value;
        if (mem_f.we && mem_f.addr == addr)
            return mem_f.value;
        return rf_val;
    endfunction

    assign opcode   = opcode_e'(if_id_i.instr[31:26]);
    assign funct    = funct_e'(if_id_i.instr[5:0]);
    assign rs       = if_id_i.instr[25:21];
    assign rt       = if_id_i.instr[20:16];
    assign rd       = if_id_i.instr[15:11];
    assign imm_sext = {{(XLEN-16){if_id_i.instr[15]}}, if_id_i.instr[15:0]};
    assign imm_zext = {{(XLEN-16){1'b0}}, if_id_i.instr[15:0]};

    assign rs_addr_o = rs;
    assign rt_addr_o = rt;
    assign rs_val    = fwd_pick(rs, rs_data_i, ex_fwd_i, mem_fwd_i);
    assign rt_val    = fwd_pick(rt, rt_data_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        alu_op     = ALU_ADD;
        wr_addr    = rt;
        use_rs     = 1'b1;
        use_rt     = 1'b0;
        use_imm    = 1'b1;
        imm_signed = 1'b1;
        wr_en      = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_rt  = 1'b1;
                use_imm = 1'b0;
                wr_addr = rd;
                wr_en   = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: wr_en  = 1'b0; // sll $0 etc. act as nop
                endcase
            end
            OP_ADDIU: wr_en = 1'b1;
            OP_ORI: begin
                alu_op     = ALU_OR;
                imm_signed = 1'b0;
                wr_en      = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                use_rs = 1'b0;
                wr_en  = 1'b1;
            end
            OP_LW: begin
                is_load = 1'b1;
                wr_en   = 1'b1;
            end
            OP_SW: begin
                is_store = 1'b1;
                use_rt   = 1'b1;
            end
            OP_BEQ: begin
                is_beq = 1'b1;
                use_rt = 1'b1;
            end
            OP_BNE: begin
                is_bne = 1'b1;
                use_rt = 1'b1;
            end
            default: use_rs = 1'b0;
        endcase
    end

    assign load_hit = ex_fwd_i.load && ex_fwd_i.we && ex_fwd_i.addr != '0 &&
                      ((use_rs && ex_fwd_i.addr == rs) || (use_rt && ex_fwd_i.addr == rt));
    assign stall_o  = if_id_i.valid && load_hit;

    assign branch_target_o = if_id_i.pc + XLEN'(4) + {imm_sext[XLEN-3:0], 2'b00};
    assign branch_taken_o  = if_id_i.valid && !stall_o &&
                             ((is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_o.valid <= 1'b0;
        end else begin
            id_ex_o.valid   <= if_id_i.valid && !stall_o; // bubble on stall
            id_ex_o.pc      <= if_id_i.pc;
            id_ex_o.alu_op  <= alu_op;
            id_ex_o.opa     <= rs_val;
            id_ex_o.opb     <= !use_imm ? rt_val : (imm_signed ? imm_sext : imm_zext);
            id_ex_o.st_data <= rt_val;
            id_ex_o.we      <= wr_en;
            id_ex_o.waddr   <= wr_addr;
            id_ex_o.load    <= is_load;
            id_ex_o.store   <= is_store;
        end
    end

    // the load moves on after one bubble, so the hazard clears by itself
    a_single_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |=> !stall_o);

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
// PC and IF/ID register. The instruction bus is read combinationally,
// so the fetched word is captured in the same cycle as the address.
// A redirect from decode is taken on the next clock edge.
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        stall_i,
    input  wire                        branch_taken_i,
    input  wire mips_isa_pkg::word_t   branch_target_i,
    output mips_isa_pkg::word_t        imem_addr_o,
    input  wire mips_isa_pkg::word_t   imem_data_i,
    output mips_pipe_pkg::if_id_t      if_id_o
);
    import mips_isa_pkg::*;

    word_t pc;
    word_t pc_next;

    assign pc_next     = branch_taken_i ? branch_target_i : pc + XLEN'(4);
    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc            <= RESET_PC;
            if_id_o.valid <= 1'b0;
        end else if (!stall_i) begin // stall holds pc and IF/ID
            pc            <= pc_next;
            if_id_o.valid <= 1'b1;
            if_id_o.pc    <= pc;
            if_id_o.instr <= imem_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== mips_pipe_pkg.sv ====
// Records carried between pipeline stages.
// Every record is qualified by its valid bit; other fields are don't-care
// when valid is low.
`default_nettype none

package mips_pipe_pkg;

    import mips_isa_pkg::*;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     opa;
        word_t     opb;
        word_t     st_data;
        logic      we;
        reg_addr_t waddr;
        logic      load;
        logic      store;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     alu_res; // effective address for LW/SW
        word_t     st_data;
        logic      we;
        reg_addr_t waddr;
        logic      load;
        logic      store;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } mem_wb_t;

    typedef struct packed {
        logic      we;    // already qualified by the stage valid bit
        reg_addr_t addr;
        word_t     value;
        logic      load;  // value not ready yet in execute
    } fwd_t;

endpackage

`default_nettype wire

// ==== mips_isa_pkg.sv ====
// MIPS32 subset constants and encodings used by the core.
// Only the opcodes and SPECIAL functions listed here are decoded;
// anything else behaves as a NOP.
`default_nettype none

package mips_isa_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0; // first fetch after reset

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT, // signed compare
        ALU_LUI  // operand b shifted to the upper half
    } alu_op_e;

endpackage

`default_nettype wire
